//--- bench/mipsCore_testdata.txt
26
00000000 8 00000004
00000004 9 fffffffb
00000008 8 00000003
00000008 8 00000002
00000008 8 00000001
00000008 8 00000000
00000010 9 fffffffc
00000010 9 fffffffd
00000010 9 fffffffe
00000010 9 ffffffff
00000010 9 00000000
00000018 10 00000000
00000028 10 00000001
00000038 16 0000000e
0000003c 17 0000000f
00000040 18 0000001d
00000044 19 00008001
00000048 8 0000002c
0000004c 8 fffffff1
00000050 8 0000000c
00000054 8 0000001f
00000058 8 00000001
0000005c 8 00000000
00000060 8 0000003c
00000064 8 00000003
0000006c 31 00000078
00000078

//--- compile.f
+incdir+logic
logic/mipsPkg.sv
logic/instructionMemory.sv
logic/fetchUnit.sv
logic/instrDecoder.sv
logic/executeUnit.sv
logic/writebackRegFile.sv
logic/mipsCore.sv
bench/mipsCoreTb.sv

//--- Bender.yml
package:
  name: mipsCore

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mipsPkg.sv
      - logic/instructionMemory.sv
      - logic/fetchUnit.sv
      - logic/instrDecoder.sv
      - logic/executeUnit.sv
      - logic/writebackRegFile.sv
      - logic/mipsCore.sv
  - target: test
    files:
      - bench/mipsCoreTb.sv

//--- bench/mipsCoreTb.sv
`timescale 1ns/1ns

module mipsCoreTb import mipsPkg::*; ();

    localparam int    clkPeriod     = 100;
    localparam int    driveDelay    = 5;  // inputs change this long after the rising edge
    localparam int    sampleDelay   = 20; // outputs read here when long settled
    localparam int    resetCycles   = 8;
    localparam int    commitTimeout = 16; // longest commit gap in the program is 3
    localparam int    haltTimeout   = 8;
    localparam int    quietCycles   = 20;
    localparam string dataFile      = "bench/mipsCore_testdata.txt";

    logic   clk;
    logic   rstN;
    wordT   pc;
    logic   commitValid;
    commitT commit;
    logic   illegalInstr;

    // expected stream filled from the data file
    wordT    expPc  [$];
    regAddrT expRd  [$];
    wordT    expVal [$];
    wordT    haltPc;

    wordT    prevPc; // pc one sample back
    wordT    curPc;

    mipsCore i_mipsCore (
        .clk         (clk),
        .rstN        (rstN),
        .pc          (pc),
        .commitValid (commitValid),
        .commit      (commit),
        .illegalInstr(illegalInstr)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    // reads the commit count, the pc / rd / value triples and the halt pc
    task automatic loadExpected();
        int   fd;
        int   n;
        int   count;
        int   r;
        wordT p;
        wordT v;
        fd = $fopen(dataFile, "r");
        if (fd == 0) stopWithFailure($sformatf("could not open data file %s", dataFile));
        n = $fscanf(fd, "%d", count);
        if (n != 1 || count <= 0) stopWithFailure("data file does not start with a commit count");
        for (int i = 0; i < count; i++) begin
            n = $fscanf(fd, "%h %d %h", p, r, v);
            if (n != 3) stopWithFailure($sformatf("data file entry %0d is incomplete", i));
            expPc.push_back(p);
            expRd.push_back(regAddrT'(r));
            expVal.push_back(v);
        end
        n = $fscanf(fd, "%h", haltPc);
        if (n != 1) stopWithFailure("data file has no halt pc after the commits");
        $fclose(fd);
    endtask

    task automatic checkResetState(input string when);
        assert (pc === '0)
            else stopWithFailure($sformatf("FAIL %0t: pc %h %s, expected 0", $time, pc, when));
        assert (commitValid === 1'b0)
            else stopWithFailure($sformatf("FAIL %0t: commitValid high %s", $time, when));
        assert (illegalInstr === 1'b0)
            else stopWithFailure($sformatf("FAIL %0t: illegalInstr high %s", $time, when));
    endtask

    // advance one edge and look at the settled outputs
    task automatic sampleCycle();
        @(posedge clk);
        #(sampleDelay);
        prevPc = curPc;
        curPc  = pc;
        assert (illegalInstr === 1'b0) // program uses only the kept subset
            else stopWithFailure($sformatf("FAIL %0t: illegalInstr high at pc %h", $time, pc));
    endtask

    task automatic waitForCommit(input int idx);
        int waited;
        waited = 0;
        sampleCycle();
        while (commitValid !== 1'b1) begin
            waited++;
            if (waited >= commitTimeout) begin
                stopWithFailure($sformatf("timed out after %0d cycles waiting for commit %0d",
                                          commitTimeout, idx));
            end
            sampleCycle();
        end
    endtask

    task automatic checkCommit(input int idx);
        assert (prevPc === expPc[idx]) // record shows up one cycle after its pc
            else stopWithFailure($sformatf("FAIL %0t: pc before commit %0d was %h, expected %h",
                                           $time, idx, prevPc, expPc[idx]));
        assert (commit.pc === expPc[idx])
            else stopWithFailure($sformatf("FAIL %0t: commit %0d pc %h, expected %h",
                                           $time, idx, commit.pc, expPc[idx]));
        assert (commit.rd === expRd[idx])
            else stopWithFailure($sformatf("FAIL %0t: commit %0d rd %0d, expected %0d",
                                           $time, idx, commit.rd, expRd[idx]));
        assert (commit.value === expVal[idx])
            else stopWithFailure($sformatf("FAIL %0t: commit %0d value %h, expected %h",
                                           $time, idx, commit.value, expVal[idx]));
    endtask

    // jr lands on halt a couple of cycles after the last write
    task automatic waitForHalt();
        int waited;
        waited = 0;
        while (curPc !== haltPc) begin
            if (waited >= haltTimeout) begin
                stopWithFailure($sformatf("timed out after %0d cycles waiting for pc to reach %h",
                                          haltTimeout, haltPc));
            end
            sampleCycle();
            waited++;
            assert (commitValid === 1'b0)
                else stopWithFailure($sformatf("FAIL %0t: extra commit from pc %h", $time, commit.pc));
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        rstN   = 1'b0;
        prevPc = '0;
        curPc  = '0;
        loadExpected();
        repeat (resetCycles) begin
            @(posedge clk);
            #(driveDelay);
            checkResetState("during reset");
        end
        rstN = 1'b1; // released driveDelay after the last reset edge
        #1;
        checkResetState("at reset release");
        foreach (expPc[i]) begin
            waitForCommit(i);
            checkCommit(i);
        end
        waitForHalt();
        repeat (quietCycles) begin
            sampleCycle();
            assert (commitValid === 1'b0)
                else stopWithFailure($sformatf("FAIL %0t: commit after halt, pc %h",
                                               $time, commit.pc));
            assert (pc === haltPc)
                else stopWithFailure($sformatf("FAIL %0t: pc %h left halt %h", $time, pc, haltPc));
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- logic/mipsCore.sv
`timescale 1ns/1ns

// single-cycle core, one instruction retired per edge
module mipsCore import mipsPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    output wordT   pc,
    output logic   commitValid,
    output commitT commit,
    output logic   illegalInstr
);

    wordT         instr;
    wordT         nextPc;
    decodedInstrT decoded;
    regAddrT      rsAddr;
    regAddrT      rtAddr;
    wordT         rsData;
    wordT         rtData;
    execResultT   result;

    //////////////////////////////
    // units
    //////////////////////////////

    fetchUnit i_fetchUnit (
        .clk   (clk),
        .rstN  (rstN),
        .nextPc(nextPc),
        .pc    (pc),
        .instr (instr)
    );

    instrDecoder i_instrDecoder (
        .instr  (instr),
        .decoded(decoded),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr)
    );

    executeUnit i_executeUnit (
        .pc     (pc),
        .decoded(decoded),
        .rsData (rsData),
        .rtData (rtData),
        .result (result),
        .nextPc (nextPc)
    );

    writebackRegFile i_writebackRegFile (
        .clk        (clk),
        .rstN       (rstN),
        .pc         (pc),
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .result     (result),
        .rsData     (rsData),
        .rtData     (rtData),
        .commitValid(commitValid),
        .commit     (commit)
    );

    assign illegalInstr = decoded.illegal; // same cycle as the fetch

endmodule

//--- logic/writebackRegFile.sv
`timescale 1ns/1ns

`include "mipsCore_defines.svh"

module writebackRegFile import mipsPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  wordT       pc,     // pc of the instruction being written
    input  regAddrT    rsAddr,
    input  regAddrT    rtAddr,
    input  execResultT result,
    output wordT       rsData,
    output wordT       rtData,
    output logic       commitValid,
    output commitT     commit
);

    wordT regs [`REG_COUNT];
    logic doWrite;

    // $zero is never written
    assign doWrite = result.writeEn && (result.rd != '0);

    //////////////////////////////
    // register array
    //////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (doWrite) begin
            regs[result.rd] <= result.aluResult;
        end
    end

    // combinational reads give the old value while a write is pending
    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

    //////////////////////////////
    // commit record
    //////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            commitValid <= 1'b0;
        end else begin
            commitValid <= doWrite; // one-cycle strobe per write
        end
    end

    always_ff @(posedge clk) begin
        commit.pc    <= pc;
        commit.rd    <= result.rd;
        commit.value <= result.aluResult;
    end

    assert property (@(posedge clk) disable iff (!rstN)
        commitValid |-> commit.rd != '0)
        else $error("commit to register zero at pc %h", commit.pc);

endmodule

//--- logic/executeUnit.sv
`timescale 1ns/1ns

`include "mipsCore_defines.svh"

module executeUnit import mipsPkg::*; (
    input  wordT         pc,
    input  decodedInstrT decoded,
    input  wordT         rsData,
    input  wordT         rtData,
    output execResultT   result,
    output wordT         nextPc
);

    wordT opB;
    wordT aluOut;
    wordT pcPlus4;
    wordT branchTarget;
    logic taken;

    //////////////////////////////
    // alu
    //////////////////////////////

    assign opB = decoded.useImm ? decoded.imm : rtData;

    always_comb begin
        case (decoded.aluOp)
            aluAdd: aluOut = rsData + opB; // no overflow trap
            aluSub: aluOut = rsData - opB;
            aluAnd: aluOut = rsData & opB;
            aluOr:  aluOut = rsData | opB;
            aluSlt: aluOut = {{(`WORD_BITS-1){1'b0}}, ($signed(rsData) < $signed(opB))};
            aluSll: aluOut = rtData << decoded.shamt; // shifts ignore rs
            aluSrl: aluOut = rtData >> decoded.shamt;
            default: aluOut = opB; // passB
        endcase
    end

    //////////////////////////////
    // branch and next pc
    //////////////////////////////

    always_comb begin
        case (decoded.branch)
            brEq:  taken = (rsData == rtData);
            brNe:  taken = (rsData != rtData);
            brGtz: taken = ($signed(rsData) > 0);
            brLtz: taken = rsData[`WORD_BITS-1];
            brJr:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign pcPlus4      = pc + 4;
    assign branchTarget = pcPlus4 + {decoded.imm[`WORD_BITS-3:0], 2'b00}; // word offset

    always_comb begin
        if (taken && decoded.branch == brJr) begin
            nextPc = rsData;
        end else if (taken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    assign result.aluResult   = aluOut;
    assign result.writeEn     = decoded.writeEn;
    assign result.rd          = decoded.rd;
    assign result.branchTaken = taken;

    always_comb begin
        if (decoded.branch == brJr && !$isunknown(rsData)) begin
            assert final (rsData[1:0] == 2'b00)
                else $error("jr to unaligned target %h at pc %h", rsData, pc);
        end
    end

endmodule

//--- logic/instrDecoder.sv
`timescale 1ns/1ns

`include "mipsCore_defines.svh"

module instrDecoder import mipsPkg::*; (
    input  wordT         instr,
    output decodedInstrT decoded,
    output regAddrT      rsAddr, // straight to the read ports
    output regAddrT      rtAddr
);

    opcodeT opcode;
    functT  funct;
    wordT   signImm;
    wordT   zeroImm;

    // field split
    assign opcode  = opcodeT'(instr[31:26]);
    assign funct   = functT'(instr[5:0]);
    assign signImm = {{(`WORD_BITS-16){instr[15]}}, instr[15:0]}; // addi, branches
    assign zeroImm = {{(`WORD_BITS-16){1'b0}}, instr[15:0]};      // ori only

    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];

    //////////////////////////////
    // control record
    //////////////////////////////

    always_comb begin
        decoded        = '0; // illegal defaults to low, writeEn too
        decoded.rs     = instr[25:21];
        decoded.rt     = instr[20:16];
        decoded.rd     = instr[20:16]; // i-type target
        decoded.shamt  = instr[10:6];
        decoded.imm    = signImm;
        decoded.aluOp  = aluPassB;
        decoded.branch = brNone;
        case (opcode)
            opSpecial: begin
                decoded.rd = instr[15:11]; // r-type target
                case (funct)
                    fnAdd: begin decoded.aluOp = aluAdd; decoded.writeEn = 1'b1; end
                    fnSub: begin decoded.aluOp = aluSub; decoded.writeEn = 1'b1; end
                    fnAnd: begin decoded.aluOp = aluAnd; decoded.writeEn = 1'b1; end
                    fnOr:  begin decoded.aluOp = aluOr;  decoded.writeEn = 1'b1; end
                    fnSlt: begin decoded.aluOp = aluSlt; decoded.writeEn = 1'b1; end
                    fnSll: begin decoded.aluOp = aluSll; decoded.writeEn = 1'b1; end // nop lands here
                    fnSrl: begin decoded.aluOp = aluSrl; decoded.writeEn = 1'b1; end
                    fnJr:  decoded.branch = brJr;
                    default: decoded.illegal = 1'b1;
                endcase
            end
            opRegimm: begin
                if (instr[20:16] == 5'd0) begin
                    decoded.branch = brLtz; // bgez and friends not kept
                end else begin
                    decoded.illegal = 1'b1;
                end
            end
            opBeq: decoded.branch = brEq;
            opBne: decoded.branch = brNe;
            opBgtz: begin
                if (instr[20:16] == 5'd0) begin
                    decoded.branch = brGtz;
                end else begin
                    decoded.illegal = 1'b1;
                end
            end
            opAddi: begin
                decoded.aluOp   = aluAdd;
                decoded.useImm  = 1'b1;
                decoded.writeEn = 1'b1;
            end
            opOri: begin
                decoded.aluOp   = aluOr;
                decoded.useImm  = 1'b1;
                decoded.imm     = zeroImm;
                decoded.writeEn = 1'b1;
            end
            default: decoded.illegal = 1'b1; // loads, stores, jumps etc
        endcase
    end

endmodule

//--- logic/fetchUnit.sv
`timescale 1ns/1ns

`include "mipsCore_defines.svh"

module fetchUnit import mipsPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  wordT nextPc, // from execute, already resolved
    output wordT pc,
    output wordT instr
);

    //////////////////////////////
    // program counter
    //////////////////////////////

    // no delay slot, next pc takes effect right away
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    instructionMemory i_instructionMemory (
        .address    (pc),
        .instruction(instr)
    );

    // a branch or jr target past the rom would fetch garbage
    assert property (@(posedge clk) disable iff (!rstN)
        pc < `IMEM_WORDS * 4)
        else $error("pc %h outside instruction memory", pc);

endmodule

//--- logic/instructionMemory.sv
`timescale 1ns/1ns

`include "mipsCore_defines.svh"

// read-only program store, word indexed
module instructionMemory import mipsPkg::*; (
    input  wordT address,
    output wordT instruction
);

    wordT rom [`IMEM_WORDS];

    //////////////////////////////
    // program
    //////////////////////////////

    initial begin
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            rom[i] = '0; // unused words read as nop
        end
        // branch loops
        rom[0]  = 32'h20080004; // main:   addi $t0, $zero, 4
        rom[1]  = 32'h2009FFFB; //         addi $t1, $zero, -5
        rom[2]  = 32'h2108FFFF; // loop:   addi $t0, $t0, -1
        rom[3]  = 32'h1D00FFFE; //         bgtz $t0, loop
        rom[4]  = 32'h21290001; // loop2:  addi $t1, $t1, 1
        rom[5]  = 32'h0520FFFE; //         bltz $t1, loop2
        // beq / bne, each one taken and one not taken
        rom[6]  = 32'h200A0000; //         addi $t2, $zero, 0
        rom[7]  = 32'h11400001; //         beq  $t2, $zero, chk1
        rom[8]  = 32'h200A0063; //         addi $t2, $zero, 99   skipped
        rom[9]  = 32'h15400001; // chk1:   bne  $t2, $zero, chk1+8
        rom[10] = 32'h200A0001; //         addi $t2, $zero, 1
        rom[11] = 32'h11400001; //         beq  $t2, $zero, chk1+16
        rom[12] = 32'h15400001; //         bne  $t2, $zero, rblk
        rom[13] = 32'h200A004D; //         addi $t2, $zero, 77   skipped
        // r-type block
        rom[14] = 32'h2010000E; // rblk:   addi $s0, $zero, 14
        rom[15] = 32'h2011000F; //         addi $s1, $zero, 15
        rom[16] = 32'h2012001D; //         addi $s2, $zero, 29
        rom[17] = 32'h34138001; //         ori  $s3, $zero, 0x8001
        rom[18] = 32'h02324020; //         add  $t0, $s1, $s2    44
        rom[19] = 32'h02124022; //         sub  $t0, $s0, $s2    -15
        rom[20] = 32'h02504024; //         and  $t0, $s2, $s0    12
        rom[21] = 32'h02504025; //         or   $t0, $s2, $s0    31
        rom[22] = 32'h0211402A; //         slt  $t0, $s0, $s1    1
        rom[23] = 32'h0230402A; //         slt  $t0, $s1, $s0    0
        rom[24] = 32'h00114080; //         sll  $t0, $s1, 2      60
        rom[25] = 32'h001240C2; //         srl  $t0, $s2, 3      3
        rom[26] = 32'h00000000; //         nop
        // jump out to halt
        rom[27] = 32'h341F0078; //         ori  $ra, $zero, 0x78
        rom[28] = 32'h03E00008; //         jr   $ra
        rom[29] = 32'h200A0037; //         addi $t2, $zero, 55   skipped
        rom[30] = 32'h1000FFFF; // halt:   beq  $zero, $zero, halt
    end

    // byte address in, low two bits dropped
    assign instruction = rom[address[`IMEM_INDEX_BITS+1:2]];

    always_comb begin
        if (!$isunknown(address)) begin
            assert final (address[1:0] == 2'b00)
                else $error("instruction fetch from unaligned address %h", address);
        end
    end

endmodule

//--- logic/mipsPkg.sv
package mipsPkg;

`include "mipsCore_defines.svh"

    typedef logic [`WORD_BITS-1:0]         wordT;    // datapath word
    typedef logic [$clog2(`REG_COUNT)-1:0] regAddrT; // register number

    //////////////////////////////
    // encodings
    //////////////////////////////

    // major opcodes, bits 31..26
    typedef enum logic [5:0] {
        opSpecial = 6'h00, // r-type, look at funct
        opRegimm  = 6'h01, // bltz when rt field is 0
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opBgtz    = 6'h07,
        opAddi    = 6'h08,
        opOri     = 6'h0D
    } opcodeT;

    // r-type function codes, bits 5..0
    typedef enum logic [5:0] {
        fnSll = 6'h00, // also nop when everything is zero
        fnSrl = 6'h02,
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2A
    } functT;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSll, aluSrl, aluPassB
    } aluOpT;

    typedef enum logic [2:0] {
        brNone, brEq, brNe, brGtz, brLtz, brJr
    } branchT;

    //////////////////////////////
    // records between the units
    //////////////////////////////

    typedef struct packed {
        regAddrT rs;       // first operand
        regAddrT rt;       // second operand
        regAddrT rd;       // destination, rd or rt by format
        aluOpT   aluOp;
        logic    useImm;   // operand b from imm instead of rt
        logic [4:0] shamt;
        wordT    imm;      // already extended
        branchT  branch;
        logic    writeEn;
        logic    illegal;
    } decodedInstrT;

    typedef struct packed {
        wordT    aluResult;
        logic    writeEn;
        regAddrT rd;
        logic    branchTaken;
    } execResultT;

    typedef struct packed {
        wordT    pc;    // address of the retiring instruction
        regAddrT rd;
        wordT    value;
    } commitT;

endpackage

//--- logic/mipsCore_defines.svh
`ifndef MIPSCORE_DEFINES_SVH
`define MIPSCORE_DEFINES_SVH

//////////////////////////////
// instruction memory geometry
//////////////////////////////

// program store depth in words
`define IMEM_WORDS 128

// index width, selects address bits 8..2
`define IMEM_INDEX_BITS 7

//////////////////////////////
// datapath
//////////////////////////////

`define WORD_BITS 32 // one machine word

// architectural registers, $zero included
`define REG_COUNT 32

`endif
